// File: rtl/video_pkg.sv
package video_pkg;

	// bus and pixel widths
	localparam int DATA_W  = 16;  // dram video word
	localparam int GROUP_W = 64;  // one group for the renderer
	localparam int PIX_W   = 2;   // bits per pixel
	localparam int ADDR_W  = 12;  // video memory address

	// line and frame timing, counted in dram cycles and lines
	localparam int LINE_CYC    = 64;
	localparam int FETCH_BEG   = 8;   // fetch window opens here
	localparam int FETCH_LEN   = 32;  // two fetch cycles
	localparam int FRAME_LINES = 8;
	localparam int VPIX_BEG    = 2;   // first visible line
	localparam int VPIX_END    = 6;   // first line past the window
	localparam int FETCH_CYC   = 16;  // dram cycles per fetch cycle

	// derived sizes
	localparam int GRP_WORDS   = GROUP_W / DATA_W;  // words per group, 4 at 1/4 bw
	localparam int PIX_PER_GRP = GROUP_W / PIX_W;   // pixels shifted out per group

	// counter widths
	localparam int HCNT_W = $clog2(LINE_CYC);
	localparam int LINE_W = $clog2(FRAME_LINES);
	localparam int FCNT_W = $clog2(FETCH_CYC);
	localparam int PTR_W  = $clog2(GRP_WORDS);
	localparam int SCNT_W = $clog2(GRP_WORDS + 1);   // must hold a full count
	localparam int PCNT_W = $clog2(PIX_PER_GRP + 1);

endpackage

// File: rtl/video_sync.sv
module video_sync (
	input  logic clk,
	input  logic rst_n,
	output logic cend,         // last clk of a dram cycle
	output logic pre_cend,     // first clk of a dram cycle
	output logic fetch_start,  // fetch window opens
	output logic fetch_end,    // fetch window closes
	output logic vpix,         // line inside vertical window
	output logic frame_start   // line 0 begins
);
	import video_pkg::*;

	logic              phase;  // dram cycle half
	logic [HCNT_W-1:0] hcnt;   // dram cycle within line
	logic [LINE_W-1:0] line;   // line within frame
	logic              hlast;  // last dram cycle of line
	logic              vlast;  // last line of frame

	// two clks per dram cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			phase <= 1'b0;
		else
			phase <= ~phase;
	end

	assign pre_cend = ~phase;
	assign cend     = phase;   // always one clk after pre_cend

	assign hlast = (hcnt == HCNT_W'(LINE_CYC - 1));
	assign vlast = (line == LINE_W'(FRAME_LINES - 1));

	// horizontal and line counters, both step on cend
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hcnt <= '0;
			line <= '0;
		end
		else if (cend)
		begin
			if (hlast)
			begin
				hcnt <= '0;
				line <= vlast ? '0 : line + 1'b1;  // wrap at frame end
			end
			else
			begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// window strobes, each one clk wide and aligned to cend
	assign fetch_start = cend && (hcnt == HCNT_W'(FETCH_BEG));
	assign fetch_end   = cend && (hcnt == HCNT_W'(FETCH_BEG + FETCH_LEN));

	// counters roll over into line 0 on this cend
	assign frame_start = cend && hlast && vlast;

	// level for the whole line, changes only on the line wrap
	assign vpix = (line >= LINE_W'(VPIX_BEG)) && (line < LINE_W'(VPIX_END));

endmodule

// File: rtl/video_arb.sv
module video_arb (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         cend,
	input  logic                         fetch_start,
	input  logic                         frame_start,
	input  logic                         video_go,      // fetch block wants data
	input  logic [video_pkg::DATA_W-1:0] mem_rdata,     // valid one clk after mem_rd
	output logic                         mem_rd,
	output logic [video_pkg::ADDR_W-1:0] mem_addr,
	output logic                         video_strobe,  // word ready for fetch
	output logic [video_pkg::DATA_W-1:0] video_data
);
	import video_pkg::*;

	logic [FCNT_W-1:0] slot;     // dram cycle within fetch cycle
	logic              rd_slot;  // slot owned by video

	// slot counter, aligned to the fetch window start
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			slot <= '0;
		else if (cend)
		begin
			if (fetch_start)
				slot <= '0;
			else
				slot <= slot + 1'b1;  // wraps modulo 16
		end
	end

	// every fourth dram cycle, so slots 3 7 11 15
	assign rd_slot = (slot[1:0] == 2'b11);

	// read request, one clk wide, issued at the end of a video slot
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mem_rd <= 1'b0;
		else
			mem_rd <= cend && video_go && rd_slot;
	end

	// address held during mem_rd, bumped once it is taken
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mem_addr <= '0;
		else if (frame_start)
			mem_addr <= '0;  // new frame reads from the top
		else if (mem_rd)
			mem_addr <= mem_addr + 1'b1;
	end

	// memory answers in the next clk
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			video_strobe <= 1'b0;
		else
			video_strobe <= mem_rd;
	end

	assign video_data = mem_rdata;  // sampled by fetch while video_strobe is up

endmodule

// File: rtl/video_fetch.sv
module video_fetch (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cend,
	input  logic                          pre_cend,
	input  logic                          vpix,          // vertical window
	input  logic                          fetch_start,
	input  logic                          fetch_end,
	input  logic [video_pkg::DATA_W-1:0]  video_data,    // word from arbiter
	input  logic                          video_strobe,
	output logic                          video_go,      // requests reads from arbiter
	output logic                          fetch_sync,    // group handed to renderer
	output logic [video_pkg::GROUP_W-1:0] pic_bits,
	output logic                          pic_valid      // group was fully filled
);
	import video_pkg::*;

	logic [FCNT_W-1:0] fetch_ctr;      // dram cycle within fetch cycle
	logic              fetch_ptr_clr;  // starts a new group
	logic [PTR_W-1:0]  fetch_ptr;      // next buffer slot
	logic [SCNT_W-1:0] stb_cnt;        // strobes since last clear
	logic [SCNT_W-1:0] grp_cnt;        // strobes in the group just closed
	logic              grp_load;       // clk before fetch_sync
	logic [DATA_W-1:0] fetch_data [GRP_WORDS];

	// fetch window, only opens on visible lines
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			video_go <= 1'b0;
		else if (fetch_start && vpix)
			video_go <= 1'b1;
		else if (fetch_end)
			video_go <= 1'b0;
	end

	// fetch cycle counter, restarted at window start
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			fetch_ctr <= '0;
		else if (cend)
			fetch_ctr <= fetch_start ? '0 : fetch_ctr + 1'b1;
	end

	assign grp_load = pre_cend && (fetch_ctr == FCNT_W'(1));

	// pointer clear lands in the same clk as the slot 15 strobe
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fetch_ptr_clr <= 1'b0;
			fetch_sync    <= 1'b0;
		end
		else
		begin
			fetch_ptr_clr <= pre_cend && (fetch_ctr == '0);
			fetch_sync    <= grp_load;
		end
	end

	// fill pointer and strobe count
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fetch_ptr <= '0;
			stb_cnt   <= '0;
			grp_cnt   <= '0;
		end
		else if (fetch_ptr_clr)
		begin
			fetch_ptr <= '0;
			stb_cnt   <= '0;
			grp_cnt   <= stb_cnt + SCNT_W'(video_strobe);  // count the last word too
		end
		else if (video_strobe)
		begin
			fetch_ptr <= fetch_ptr + 1'b1;
			stb_cnt   <= stb_cnt + 1'b1;
		end
	end

	// word buffer
	always_ff @(posedge clk)
	begin
		if (video_strobe)
			fetch_data[fetch_ptr] <= video_data;
	end

	// group out, bytes swapped within each word, valid together with fetch_sync
	always_ff @(posedge clk)
	begin
		if (grp_load)
			for (int i = 0; i < GRP_WORDS; i++)
				pic_bits[i*DATA_W +: DATA_W] <= {fetch_data[i][7:0], fetch_data[i][15:8]};
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pic_valid <= 1'b0;
		else if (grp_load)
			pic_valid <= (grp_cnt == SCNT_W'(GRP_WORDS));  // partial groups dropped
	end

endmodule

// File: rtl/video_render.sv
module video_render (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          fetch_sync,  // group available
	input  logic [video_pkg::GROUP_W-1:0] pic_bits,
	input  logic                          pic_valid,
	output logic [video_pkg::PIX_W-1:0]   pix,
	output logic                          pix_valid
);
	import video_pkg::*;

	logic [GROUP_W-1:0] shreg;     // pixel shifter, lsb goes out first
	logic [PCNT_W-1:0]  pix_left;  // pixels still to show
	logic               load;

	// invalid groups are ignored, the line stays blank
	assign load = fetch_sync && pic_valid;

	// load a group or step to the next pixel
	always_ff @(posedge clk)
	begin
		if (load)
			shreg <= pic_bits;
		else
			shreg <= shreg >> PIX_W;
	end

	// pixel counter, a new group may land on the last pixel
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pix_left <= '0;
		else if (load)
			pix_left <= PCNT_W'(PIX_PER_GRP);
		else if (pix_left != '0)
			pix_left <= pix_left - 1'b1;
	end

	assign pix       = shreg[PIX_W-1:0];
	assign pix_valid = (pix_left != '0);  // one pixel per clk while counting

endmodule

// File: rtl/video_top.sv
module video_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [video_pkg::DATA_W-1:0] mem_rdata,
	output logic                         mem_rd,
	output logic [video_pkg::ADDR_W-1:0] mem_addr,
	output logic [video_pkg::PIX_W-1:0]  pix,
	output logic                         pix_valid
);
	import video_pkg::*;

	// timing
	logic cend;
	logic pre_cend;
	logic fetch_start;
	logic fetch_end;
	logic vpix;
	logic frame_start;

	// arbiter to fetch
	logic              video_go;
	logic              video_strobe;
	logic [DATA_W-1:0] video_data;

	// fetch to renderer
	logic               fetch_sync;
	logic [GROUP_W-1:0] pic_bits;
	logic               pic_valid;

	video_sync u_sync (
		.clk         (clk),
		.rst_n       (rst_n),
		.cend        (cend),
		.pre_cend    (pre_cend),
		.fetch_start (fetch_start),
		.fetch_end   (fetch_end),
		.vpix        (vpix),
		.frame_start (frame_start)
	);

	video_arb u_arb (
		.clk          (clk),
		.rst_n        (rst_n),
		.cend         (cend),
		.fetch_start  (fetch_start),
		.frame_start  (frame_start),
		.video_go     (video_go),
		.mem_rdata    (mem_rdata),
		.mem_rd       (mem_rd),
		.mem_addr     (mem_addr),
		.video_strobe (video_strobe),
		.video_data   (video_data)
	);

	video_fetch u_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.cend         (cend),
		.pre_cend     (pre_cend),
		.vpix         (vpix),
		.fetch_start  (fetch_start),
		.fetch_end    (fetch_end),
		.video_data   (video_data),
		.video_strobe (video_strobe),
		.video_go     (video_go),
		.fetch_sync   (fetch_sync),
		.pic_bits     (pic_bits),
		.pic_valid    (pic_valid)
	);

	video_render u_render (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_sync (fetch_sync),
		.pic_bits   (pic_bits),
		.pic_valid  (pic_valid),
		.pix        (pix),
		.pix_valid  (pix_valid)
	);

endmodule

// File: tb/tb_video_top.sv
module tb_video_top;
	timeunit 1ns;
	timeprecision 100ps;
	import video_pkg::*;

	localparam logic [31:0] SEED = 32'h1f7eb188;
	localparam int MEM_AW    = 12;              // video memory address bits
	localparam int LINE_CLK  = 128;             // clks per line
	localparam int RUN_LINES = 16;              // two frames
	localparam int RUN_CLK   = RUN_LINES * LINE_CLK;
	localparam int T_RST   = 0;
	localparam int T_RD    = 1;
	localparam int T_PIX   = 2;
	localparam int T_CNT   = 3;
	localparam int T_BLANK = 4;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic [DATA_W-1:0]    mem_rdata;
	logic                 mem_rd;
	logic [MEM_AW-1:0]    mem_addr;
	logic [PIX_W-1:0]     pix;
	logic                 pix_valid;

	logic [DATA_W-1:0] mem [1 << MEM_AW];  // random video memory
	logic [DATA_W-1:0] word_q [$];         // words returned, not yet grouped
	logic [PIX_W-1:0]  pix_q [$];          // expected pixels in display order
	int                cyc;                // clks since reset release
	int                rd_cnt [RUN_LINES];
	int                pix_cnt [RUN_LINES];
	int                fails [5];
	int                exp_addr;
	int                rd_frame;
	int                first_rd;           // line of the first read
	int                total_pix;
	logic              rd_pend;            // answer due on next edge
	logic [MEM_AW-1:0] rd_addr;
	logic              timed_out;

	video_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_rdata (mem_rdata),
		.mem_rd    (mem_rd),
		.mem_addr  (mem_addr),
		.pix       (pix),
		.pix_valid (pix_valid)
	);

	always #10 clk = ~clk;  // 20 ns period

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual, input int test);
		if (expected !== actual)
		begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
			fails[test]++;
		end
	endtask

	// four words, bytes swapped, 2-bit fields lsb first
	task automatic expand_group();
		logic [DATA_W-1:0] w;
		logic [7:0]        b;
		for (int i = 0; i < 4; i++)
		begin
			w = word_q.pop_front();
			for (int h = 0; h < 2; h++)
			begin
				b = (h == 0) ? w[15:8] : w[7:0];  // high byte lands lower
				for (int j = 0; j < 4; j++)
					pix_q.push_back(b[2*j +: 2]);
			end
		end
	endtask

	// memory answer at +1 ns, sampling at +5 ns
	always @(posedge clk)
	begin
		int  line_idx;
		int  lf;
		logic visible;
		#1;
		if (rd_pend)
		begin
			mem_rdata = mem[rd_addr];  // one clk after mem_rd
			word_q.push_back(mem[rd_addr]);
			if (word_q.size() == 4)
				expand_group();
			rd_pend = 1'b0;
		end
		#4;
		if (!rst_n)
		begin
			check("mem_rd", 0, 32'(mem_rd), T_RST);
			check("pix_valid", 0, 32'(pix_valid), T_RST);
		end
		else if (cyc < RUN_CLK)
		begin
			line_idx = cyc / LINE_CLK;
			lf       = line_idx % 8;
			visible  = (lf >= 2) && (lf <= 5);
			if (mem_rd)
			begin
				if (first_rd < 0)
					first_rd = line_idx;
				if (line_idx / 8 != rd_frame)
				begin
					rd_frame = line_idx / 8;  // address restarts per frame
					exp_addr = 0;
				end
				if (!visible)
					check("mem_rd", 0, 1, (line_idx < 2) ? T_RST : T_RD);
				check("mem_addr", exp_addr, 32'(mem_addr), T_RD);
				exp_addr++;
				rd_cnt[line_idx]++;
			end
			if (pix_valid)
			begin
				pix_cnt[line_idx]++;
				total_pix++;
				if (!visible || rd_cnt[line_idx] == 0)
					check("pix_valid", 0, 1, (line_idx < 2) ? T_RST : T_BLANK);
				if (pix_q.size() == 0)
				begin
					$display("pixel shown at %0t with no pixel left in the model", $time);
					fails[T_PIX]++;
				end
				else
					check("pix", 32'(pix_q.pop_front()), 32'(pix), T_PIX);
			end
		end
		if (rst_n && mem_rd)
		begin
			rd_pend = 1'b1;
			rd_addr = mem_addr;
		end
		if (rst_n)
			cyc++;
	end

	function automatic bit reached(input int what);
		case (what)
			0:       return first_rd >= 0;
			1:       return total_pix >= 512;
			default: return cyc >= RUN_CLK;
		endcase
	endfunction

	task automatic wait_for(input int what, input int limit, input string name);
		int n;
		n = 0;
		while (!timed_out && !reached(what))
		begin
			@(posedge clk);
			#6;  // after the monitor sample
			n++;
			if (n > limit)
			begin
				$display("timeout while waiting for %s", name);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic report_test(input int id, input string name);
		$display("test %0d %s: %s", id + 1, name, (fails[id] == 0) ? "pass" : "FAIL");
	endtask

	initial
	begin
		int n_bad;
		void'($urandom(SEED));
		for (int a = 0; a < (1 << MEM_AW); a++)
			mem[a] = DATA_W'($urandom());
		for (int l = 0; l < RUN_LINES; l++)
		begin
			rd_cnt[l]  = 0;
			pix_cnt[l] = 0;
		end
		for (int t = 0; t < 5; t++)
			fails[t] = 0;
		rst_n     = 1'b0;
		mem_rdata = '0;
		rd_pend   = 1'b0;
		rd_addr   = '0;
		cyc       = 0;
		exp_addr  = 0;
		rd_frame  = -1;
		first_rd  = -1;
		total_pix = 0;
		timed_out = 1'b0;
		n_bad     = 0;
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;

		wait_for(0, 400, "the first video read");
		check("first read line", 2, first_rd, T_RST);  // first visible line
		report_test(T_RST, "reset and idle lines");
		wait_for(1, 2200, "512 valid pixels");
		wait_for(2, 400, "the end of the second frame");
		for (int l = 0; l < RUN_LINES; l++)
		begin
			check($sformatf("reads in line %0d", l),
				((l % 8) >= 2 && (l % 8) <= 5) ? 8 : 0, rd_cnt[l], T_RD);
			check($sformatf("pixels in line %0d", l),
				((l % 8) >= 2 && (l % 8) <= 5) ? 64 : 0, pix_cnt[l], T_CNT);
		end
		check("reads in last frame", 32, exp_addr, T_RD);
		check("total pixels", 512, total_pix, T_CNT);
		check("pixel model queue", 0, pix_q.size(), T_CNT);  // nothing left unshown
		check("word log queue", 0, word_q.size(), T_CNT);
		report_test(T_RD, "read pattern");
		report_test(T_PIX, "pixel data");
		report_test(T_CNT, "pixel count");
		report_test(T_BLANK, "blank lines");
		for (int t = 0; t < 5; t++)
			if (fails[t] != 0)
				n_bad++;
		$display("summary: %0d of 5 ok, %0d failing, timeout %0d", 5 - n_bad, n_bad, timed_out);
		if (timed_out || n_bad != 0)
			$display("tests failed");
		else
			$display("all tests passed");
		$finish;
	end

endmodule

// File: build.f
rtl/video_pkg.sv
rtl/video_sync.sv
rtl/video_arb.sv
rtl/video_fetch.sv
rtl/video_render.sv
rtl/video_top.sv
tb/tb_video_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_video_top -f build.f \
	--Mdir obj_dir -o sim_video

./obj_dir/sim_video > sim.log
cat sim.log

grep -qx "all tests passed" sim.log
